//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  funct_t;

    // bit 2 inverts b, bits 1:0 pick and, or, sum or slt
    typedef logic [2:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_AND = 3'b000;
    localparam alu_ctrl_t ALU_OR  = 3'b001;
    localparam alu_ctrl_t ALU_ADD = 3'b010;
    localparam alu_ctrl_t ALU_SUB = 3'b110;
    localparam alu_ctrl_t ALU_SLT = 3'b111;

    localparam op_t OP_RTYPE = 6'h00;
    localparam op_t OP_J     = 6'h02;
    localparam op_t OP_BEQ   = 6'h04;
    localparam op_t OP_ADDI  = 6'h08;
    localparam op_t OP_LW    = 6'h23;
    localparam op_t OP_SW    = 6'h2b;

    localparam funct_t F_ADD = 6'h20;
    localparam funct_t F_SUB = 6'h22;
    localparam funct_t F_AND = 6'h24;
    localparam funct_t F_OR  = 6'h25;
    localparam funct_t F_SLT = 6'h2a;

    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10
    } alu_op_t;

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::alu_ctrl_t alu_ctrl,
    output mips_pkg::word_t     result,
    output logic                zero
);

    mips_pkg::word_t b_mux;
    mips_pkg::word_t sum;
    mips_pkg::word_t and_ab;
    mips_pkg::word_t or_ab;
    mips_pkg::word_t slt_res;
    mips_pkg::word_t mux_lo;
    mips_pkg::word_t mux_hi;

    // subtract by adding the inverted operand with a carry in of one
    assign b_mux = alu_ctrl[2] ? ~b : b;
    assign sum   = a + b_mux + mips_pkg::word_t'(alu_ctrl[2]);

    // the logic results see the same operand as the adder
    assign and_ab = a & b_mux;
    assign or_ab  = a | b_mux;

    // sign of a minus b, overflow is not taken into account
    assign slt_res = {31'b0, sum[31]};

    assign mux_lo = alu_ctrl[1] ? sum : and_ab;
    assign mux_hi = alu_ctrl[1] ? slt_res : or_ab;
    assign result = alu_ctrl[0] ? mux_hi : mux_lo;

    // flag compares the operands directly rather than the result
    assign zero = (a == b);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_idx_t ra1,
    input  mips_pkg::reg_idx_t ra2,
    output mips_pkg::word_t    rd1,
    output mips_pkg::word_t    rd2,
    input  logic               we,
    input  mips_pkg::reg_idx_t wa,
    input  mips_pkg::word_t    wd
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // register 0 always reads as zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic                rst,
    input  mips_pkg::op_t       op,
    input  mips_pkg::funct_t    funct,
    input  logic                zero,
    output logic                reg_write,
    output logic                reg_dst,
    output logic                alu_src,
    output logic                mem_write,
    output logic                mem_to_reg,
    output logic                pc_src,
    output logic                jump,
    output mips_pkg::alu_ctrl_t alu_ctrl
);

    logic              reg_write_d;
    logic              mem_write_d;
    logic              branch;
    logic              funct_ok;
    mips_pkg::alu_op_t alu_op;

    // main decoder
    always_comb begin
        reg_write_d = 1'b0;
        reg_dst     = 1'b0;
        alu_src     = 1'b0;
        mem_write_d = 1'b0;
        mem_to_reg  = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        alu_op      = mips_pkg::ALUOP_ADD;
        case (op)
            mips_pkg::OP_RTYPE: begin
                reg_write_d = 1'b1;
                reg_dst     = 1'b1;
                alu_op      = mips_pkg::ALUOP_FUNCT;
            end
            mips_pkg::OP_LW: begin
                reg_write_d = 1'b1;
                alu_src     = 1'b1;
                mem_to_reg  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                alu_src     = 1'b1;
                mem_write_d = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                branch = 1'b1;
                alu_op = mips_pkg::ALUOP_SUB;
            end
            mips_pkg::OP_ADDI: begin
                reg_write_d = 1'b1;
                alu_src     = 1'b1;
            end
            mips_pkg::OP_J: jump = 1'b1;
            default: ;
        endcase
    end

    // ALU decoder, an unknown funct suppresses the register write
    always_comb begin
        funct_ok = 1'b1;
        alu_ctrl = mips_pkg::ALU_ADD;
        case (alu_op)
            mips_pkg::ALUOP_SUB: alu_ctrl = mips_pkg::ALU_SUB;
            mips_pkg::ALUOP_FUNCT: begin
                case (funct)
                    mips_pkg::F_ADD: alu_ctrl = mips_pkg::ALU_ADD;
                    mips_pkg::F_SUB: alu_ctrl = mips_pkg::ALU_SUB;
                    mips_pkg::F_AND: alu_ctrl = mips_pkg::ALU_AND;
                    mips_pkg::F_OR:  alu_ctrl = mips_pkg::ALU_OR;
                    mips_pkg::F_SLT: alu_ctrl = mips_pkg::ALU_SLT;
                    default:         funct_ok = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign reg_write = reg_write_d & funct_ok & ~rst;
    assign mem_write = mem_write_d & ~rst;
    assign pc_src    = branch & zero;

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int DMEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            we,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wd,
    output mips_pkg::word_t rd
);

    mips_pkg::word_t mem [DMEM_WORDS];
    mips_pkg::word_t idx;

    // word index wraps around the array size
    assign idx = (addr >> 2) % DMEM_WORDS;

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::word_t     instr,
    output mips_pkg::word_t     pc,
    output mips_pkg::op_t       op,
    output mips_pkg::funct_t    funct,
    input  logic                reg_write,
    input  logic                reg_dst,
    input  logic                alu_src,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                pc_src,
    input  logic                jump,
    input  mips_pkg::alu_ctrl_t alu_ctrl,
    output logic                zero,
    output logic                reg_we,
    output mips_pkg::reg_idx_t  reg_waddr,
    output mips_pkg::word_t     reg_wdata,
    output logic                mem_we,
    output mips_pkg::word_t     mem_addr,
    output mips_pkg::word_t     mem_wdata
);

    mips_pkg::reg_idx_t rs;
    mips_pkg::reg_idx_t rt;
    mips_pkg::reg_idx_t rd;
    mips_pkg::word_t    imm_ext;
    mips_pkg::word_t    pc_plus4;
    mips_pkg::word_t    pc_branch;
    mips_pkg::word_t    pc_jump;
    mips_pkg::word_t    pc_next;
    mips_pkg::word_t    src_a;
    mips_pkg::word_t    reg_b;
    mips_pkg::word_t    src_b;
    mips_pkg::word_t    alu_result;
    mips_pkg::word_t    read_data;

    assign op    = instr[31:26];
    assign funct = instr[5:0];
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];

    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    assign pc_plus4  = pc + 32'd4;
    assign pc_branch = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign pc_jump   = {pc_plus4[31:28], instr[25:0], 2'b00};

    // jump wins over a taken branch, the two never come from one opcode anyway
    assign pc_next = jump ? pc_jump : (pc_src ? pc_branch : pc_plus4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .ra1 (rs),
        .ra2 (rt),
        .rd1 (src_a),
        .rd2 (reg_b),
        .we  (reg_write),
        .wa  (reg_waddr),
        .wd  (reg_wdata)
    );

    assign src_b = alu_src ? imm_ext : reg_b;

    alu u_alu (
        .a        (src_a),
        .b        (src_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk  (clk),
        .we   (mem_write),
        .addr (alu_result),
        .wd   (reg_b),
        .rd   (read_data)
    );

    assign reg_we    = reg_write;
    assign reg_waddr = reg_dst ? rd : rt;
    assign reg_wdata = mem_to_reg ? read_data : alu_result;

    assign mem_we    = mem_write;
    assign mem_addr  = alu_result;
    assign mem_wdata = reg_b;

endmodule

`default_nettype wire

//--- hw/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    instr,
    output mips_pkg::word_t    pc,
    output logic               reg_we,
    output mips_pkg::reg_idx_t reg_waddr,
    output mips_pkg::word_t    reg_wdata,
    output logic               mem_we,
    output mips_pkg::word_t    mem_addr,
    output mips_pkg::word_t    mem_wdata
);

    mips_pkg::op_t       op;
    mips_pkg::funct_t    funct;
    mips_pkg::alu_ctrl_t alu_ctrl;
    logic                zero;
    logic                reg_write;
    logic                reg_dst;
    logic                alu_src;
    logic                mem_write;
    logic                mem_to_reg;
    logic                pc_src;
    logic                jump;

    control_unit u_control_unit (
        .rst        (rst),
        .op         (op),
        .funct      (funct),
        .zero       (zero),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .pc_src     (pc_src),
        .jump       (jump),
        .alu_ctrl   (alu_ctrl)
    );

    datapath #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_datapath (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .pc         (pc),
        .op         (op),
        .funct      (funct),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .pc_src     (pc_src),
        .jump       (jump),
        .alu_ctrl   (alu_ctrl),
        .zero       (zero),
        .reg_we     (reg_we),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/mips_core_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_chk (
    input logic               clk,
    input logic               rst,
    input mips_pkg::word_t    pc,
    input logic               reg_we,
    input mips_pkg::reg_idx_t reg_waddr,
    input logic               mem_we,
    input mips_pkg::word_t    reg0
);

    int assert_fails = 0;

    a_pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
        else begin
            assert_fails++;
            $error("pc is not zero in the first cycle after reset");
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            assert_fails++;
            $error("pc is not word aligned");
        end

    a_one_write: assert property (@(posedge clk) !(reg_we && mem_we))
        else begin
            assert_fails++;
            $error("register write and memory write in the same cycle");
        end

    // a write aimed at register 0 must leave it at zero
    a_reg0_kept: assert property (@(posedge clk) disable iff (rst)
        reg_we && reg_waddr == 5'd0 |=> reg0 == '0)
        else begin
            assert_fails++;
            $error("register 0 changed after a write to it");
        end

    a_reset_quiet: assert property (@(posedge clk) rst |-> !reg_we && !mem_we)
        else begin
            assert_fails++;
            $error("write strobe active during reset");
        end

endmodule

bind mips_core mips_core_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .reg_we    (reg_we),
    .reg_waddr (reg_waddr),
    .mem_we    (mem_we),
    .reg0      (u_datapath.u_reg_file.regs[0])
);

`default_nettype wire

//--- verif/mips_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module mips_monitor #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    instr,
    input  mips_pkg::word_t    pc,
    input  logic               reg_we,
    input  mips_pkg::reg_idx_t reg_waddr,
    input  mips_pkg::word_t    reg_wdata,
    input  logic               mem_we,
    input  mips_pkg::word_t    mem_addr,
    input  mips_pkg::word_t    mem_wdata,
    output int                 check_count,
    output int                 err_count
);

    mips_pkg::word_t    model_regs [32];
    mips_pkg::word_t    model_mem [DMEM_WORDS];
    mips_pkg::word_t    model_pc;
    logic               exp_reg_we;
    mips_pkg::reg_idx_t exp_waddr;
    mips_pkg::word_t    exp_wdata;
    logic               exp_mem_we;
    mips_pkg::word_t    exp_maddr;
    mips_pkg::word_t    exp_mwdata;
    mips_pkg::word_t    exp_next_pc;

    // ISA model of one instruction, reads the model state and changes nothing
    function automatic void ref_step(
        input  mips_pkg::word_t    ins,
        input  mips_pkg::word_t    cur_pc,
        output logic               rwe,
        output mips_pkg::reg_idx_t wa,
        output mips_pkg::word_t    wd,
        output logic               mwe,
        output mips_pkg::word_t    maddr,
        output mips_pkg::word_t    mwd,
        output mips_pkg::word_t    npc
    );
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t imm;
        mips_pkg::word_t pc4;
        mips_pkg::word_t diff;
        a     = model_regs[ins[25:21]];
        b     = model_regs[ins[20:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        pc4   = cur_pc + 32'd4;
        rwe   = 1'b0;
        wa    = ins[20:16];
        wd    = '0;
        mwe   = 1'b0;
        maddr = '0;
        mwd   = '0;
        npc   = pc4;
        case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
                rwe = 1'b1;
                wa  = ins[15:11];
                diff = a - b;
                case (ins[5:0])
                    mips_pkg::F_ADD: wd = a + b;
                    mips_pkg::F_SUB: wd = diff;
                    mips_pkg::F_AND: wd = a & b;
                    mips_pkg::F_OR:  wd = a | b;
                    // slt is the sign of a minus b
                    mips_pkg::F_SLT: wd = {31'b0, diff[31]};
                    default:         rwe = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                rwe = 1'b1;
                wd  = a + imm;
            end
            mips_pkg::OP_LW: begin
                rwe = 1'b1;
                wd  = model_mem[((a + imm) >> 2) % DMEM_WORDS];
            end
            mips_pkg::OP_SW: begin
                mwe   = 1'b1;
                maddr = a + imm;
                mwd   = b;
            end
            mips_pkg::OP_BEQ: begin
                if (a == b) begin
                    npc = pc4 + (imm << 2);
                end
            end
            mips_pkg::OP_J: npc = {pc4[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
    endfunction

    task automatic compare_word(
        input mips_pkg::word_t got,
        input mips_pkg::word_t exp,
        input string           what
    );
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // data memory keeps its contents across reset, as the core's does
    initial begin
        check_count = 0;
        err_count   = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            compare_word(32'(reg_we), 32'd0, "reg_we during reset");
            compare_word(32'(mem_we), 32'd0, "mem_we during reset");
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc = '0;
        end else begin
            compare_word(pc, model_pc, "pc");
            ref_step(instr, model_pc, exp_reg_we, exp_waddr, exp_wdata,
                     exp_mem_we, exp_maddr, exp_mwdata, exp_next_pc);
            compare_word(32'(reg_we), 32'(exp_reg_we), "reg_we");
            if (exp_reg_we) begin
                compare_word(32'(reg_waddr), 32'(exp_waddr), "reg_waddr");
                compare_word(reg_wdata, exp_wdata, "reg_wdata");
                if (exp_waddr != 5'd0) begin
                    model_regs[exp_waddr] = exp_wdata;
                end
            end
            compare_word(32'(mem_we), 32'(exp_mem_we), "mem_we");
            if (exp_mem_we) begin
                compare_word(mem_addr, exp_maddr, "mem_addr");
                compare_word(mem_wdata, exp_mwdata, "mem_wdata");
                model_mem[(exp_maddr >> 2) % DMEM_WORDS] = exp_mwdata;
            end
            model_pc = exp_next_pc;
        end
    end

endmodule

`default_nettype wire

//--- verif/mips_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_tb;

    localparam int DMEM_WORDS   = 64;
    localparam int PROG_WORDS   = 64;
    localparam int TEST_COUNT   = 5;
    localparam int MAX_TEST_LEN = 20;
    localparam int RESET_CYCLES = 3;
    localparam int CLK_NS       = 100;
    localparam int MARGIN_NS    = 2000;

    logic               clk;
    logic               rst;
    mips_pkg::word_t    instr;
    mips_pkg::word_t    pc;
    logic               reg_we;
    mips_pkg::reg_idx_t reg_waddr;
    mips_pkg::word_t    reg_wdata;
    logic               mem_we;
    mips_pkg::word_t    mem_addr;
    mips_pkg::word_t    mem_wdata;
    int                 mon_checks;
    int                 mon_errors;

    mips_pkg::word_t prog [PROG_WORDS];
    mips_pkg::word_t prog_q [$];
    mips_pkg::word_t seed;
    int              tests_run;
    int              hang_count;

    tb_clk_gen #(.PERIOD_NS (CLK_NS)) u_clk_gen (.clk (clk));

    mips_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .pc        (pc),
        .reg_we    (reg_we),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    mips_monitor #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_monitor (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .pc          (pc),
        .reg_we      (reg_we),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .check_count (mon_checks),
        .err_count   (mon_errors)
    );

    // instruction memory answers in the same cycle
    assign instr = prog[pc[7:2]];

    function automatic mips_pkg::word_t lcg_next(input mips_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] rand16();
        seed = lcg_next(seed);
        return seed[31:16];
    endfunction

    function automatic mips_pkg::reg_idx_t rand_reg(input int lo, input int span);
        return mips_pkg::reg_idx_t'(lo + rand16() % span);
    endfunction

    function automatic mips_pkg::word_t r_type(
        input mips_pkg::funct_t   f,
        input mips_pkg::reg_idx_t rd,
        input mips_pkg::reg_idx_t rs,
        input mips_pkg::reg_idx_t rt
    );
        return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic mips_pkg::word_t i_type(
        input mips_pkg::op_t      op,
        input mips_pkg::reg_idx_t rt,
        input mips_pkg::reg_idx_t rs,
        input logic [15:0]        imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t j_type(input logic [25:0] target);
        return {mips_pkg::OP_J, target};
    endfunction

    function automatic mips_pkg::funct_t pick_funct(input int sel);
        case (sel)
            0:       return mips_pkg::F_ADD;
            1:       return mips_pkg::F_SUB;
            2:       return mips_pkg::F_AND;
            3:       return mips_pkg::F_OR;
            default: return mips_pkg::F_SLT;
        endcase
    endfunction

    function automatic int error_total();
        return mon_errors + UUT.u_chk.assert_fails + hang_count;
    endfunction

    // unused words jump to themselves, so a program halts at its end
    task automatic run_program(input string name);
        int errs_before;
        int cycles;
        mips_pkg::word_t halt_pc;
        errs_before = error_total();
        halt_pc = 32'(prog_q.size() * 4);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = (i < prog_q.size()) ? prog_q[i] : j_type(26'(i));
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (pc !== halt_pc && cycles < MAX_TEST_LEN + 2) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== halt_pc) begin
            hang_count++;
            $display("test %s: pc never reached the end of the program", name);
        end
        @(negedge clk);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, error_total() - errs_before);
    endtask

    task automatic test_reset_step();
        prog_q.delete();
        // a store sits at pc 0, so it is presented while rst is still high
        prog_q.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, 16'h0000));
        for (int i = 0; i < 8; i++) begin
            prog_q.push_back(i_type(mips_pkg::OP_ADDI, rand_reg(1, 31), 5'd0, rand16()));
        end
        run_program("reset and pc step");
    endtask

    task automatic test_alu();
        logic [15:0] imm;
        prog_q.delete();
        for (int i = 1; i <= 6; i++) begin
            imm = rand16();
            // r1 is kept negative so slt sees a negative operand
            if (i == 1) begin
                imm[15] = 1'b1;
            end
            prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'(i), 5'd0, imm));
        end
        for (int i = 0; i < 8; i++) begin
            prog_q.push_back(r_type(pick_funct(rand16() % 5), rand_reg(7, 9),
                                    rand_reg(1, 6), rand_reg(1, 6)));
        end
        prog_q.push_back(r_type(mips_pkg::F_SLT, 5'd7, 5'd1, 5'd2));
        prog_q.push_back(r_type(mips_pkg::F_SLT, 5'd8, 5'd2, 5'd1));
        run_program("arithmetic and logic");
    endtask

    task automatic test_reg_zero();
        prog_q.delete();
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, rand16()));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0055));
        prog_q.push_back(r_type(mips_pkg::F_ADD, 5'd0, 5'd1, 5'd1));
        prog_q.push_back(r_type(mips_pkg::F_ADD, 5'd2, 5'd0, 5'd1));
        prog_q.push_back(r_type(mips_pkg::F_OR, 5'd3, 5'd0, 5'd0));
        prog_q.push_back(i_type(mips_pkg::OP_LW, 5'd0, 5'd0, 16'h0000));
        prog_q.push_back(r_type(mips_pkg::F_SUB, 5'd4, 5'd1, 5'd0));
        prog_q.push_back(i_type(mips_pkg::OP_SW, 5'd0, 5'd0, 16'h0004));
        run_program("register zero");
    endtask

    task automatic test_memory();
        logic [15:0] offs [4];
        prog_q.delete();
        for (int k = 0; k < 4; k++) begin
            offs[k] = (rand16() % 16'd64) << 2;
            prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'(k + 1), 5'd0, rand16()));
        end
        for (int k = 0; k < 4; k++) begin
            prog_q.push_back(i_type(mips_pkg::OP_SW, 5'(k + 1), 5'd0, offs[k]));
        end
        for (int k = 0; k < 4; k++) begin
            prog_q.push_back(i_type(mips_pkg::OP_LW, 5'(k + 5), 5'd0, offs[k]));
        end
        prog_q.push_back(r_type(mips_pkg::F_ADD, 5'd9, 5'd5, 5'd6));
        run_program("memory store and load");
    endtask

    task automatic test_control_flow();
        prog_q.delete();
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd5));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'd7));
        prog_q.push_back(i_type(mips_pkg::OP_BEQ, 5'd3, 5'd1, 16'd2));
        prog_q.push_back(i_type(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'd1));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'd2));
        prog_q.push_back(j_type(26'd10));
        prog_q.push_back(i_type(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd0));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd5, 5'd0, 16'd3));
        prog_q.push_back(i_type(mips_pkg::OP_ADDI, 5'd6, 5'd0, 16'd9));
        // r4 must still be zero here if the branch skipped its writes
        prog_q.push_back(r_type(mips_pkg::F_ADD, 5'd7, 5'd4, 5'd6));
        run_program("branch and jump");
    endtask

    initial begin
        rst        = 1'b1;
        seed       = 32'h02481721;
        tests_run  = 0;
        hang_count = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = j_type(26'(i));
        end
        test_reset_step();
        test_alu();
        test_reg_zero();
        test_memory();
        test_control_flow();
        $display("%0d tests, %0d checks, %0d errors", tests_run, mon_checks, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(TEST_COUNT * (MAX_TEST_LEN + RESET_CYCLES + 5) * CLK_NS + MARGIN_NS);
        $display("run timed out before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/mips_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/control_unit.sv
hw/data_mem.sv
hw/datapath.sv
hw/mips_core.sv
verif/tb_clk_gen.sv
verif/mips_core_chk.sv
verif/mips_monitor.sv
verif/mips_tb.sv
